// ==== logic/fp_mul_pkg.sv ====
`default_nettype none

package fp_mul_pkg;

    // exponent bias for binary32
    localparam int EXP_BIAS = 127;

    localparam logic [7:0]  EXP_ALL_ONES = 8'hff;
    localparam logic [31:0] QNAN         = 32'h7fc00000;
    // largest finite magnitude, sign added by the rounder
    localparam logic [30:0] MAX_FINITE   = 31'h7f7fffff;

    // codes 101..111 behave as RNE
    typedef enum logic [2:0] {
        RNE = 3'b000,
        RTZ = 3'b001,
        RDN = 3'b010,
        RUP = 3'b011,
        RMM = 3'b100
    } rmode_e;

    // is_zero covers subnormals too
    typedef struct packed {
        logic is_zero;
        logic is_inf;
        logic is_nan;
    } fp_class_t;

    // after stage 1, product is zero when special is set
    typedef struct packed {
        logic               sign;
        logic signed [9:0]  exp_sum;
        logic [47:0]        product;
        logic               special;
        logic [31:0]        special_z;
        rmode_e             r_mode;
    } prod_stage_t;

    // mant is {1.frac[22:0], guard, round, sticky}
    typedef struct packed {
        logic               sign;
        logic signed [9:0]  exp;
        logic [26:0]        mant;
        logic               norm_n;
        logic               special;
        logic [31:0]        special_z;
        rmode_e             r_mode;
    } norm_stage_t;

endpackage

`default_nettype wire

// ==== logic/fp_booth_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_booth_mul #(
    parameter int MANT_W = 24
) (
    input  logic [MANT_W-1:0]   a,
    input  logic [MANT_W-1:0]   b,
    output logic [2*MANT_W-1:0] p
);

    // one extra digit keeps the unsigned msb of b positive
    localparam int ND = MANT_W / 2 + 1;
    localparam int PW = 2 * MANT_W;

    logic [MANT_W+2:0] b_ext;
    logic [PW-1:0]     pp [ND];
    logic [PW-1:0]     acc;

    assign b_ext = {2'b00, b, 1'b0};

    for (genvar i = 0; i < ND; i++) begin : g_digit
        logic [2:0]        dig;
        logic [MANT_W+1:0] mag;
        logic [PW-1:0]     mag_ext;

        assign dig = b_ext[2*i +: 3];

        // recoded digit magnitude, 0 / 1a / 2a
        always_comb begin
            case (dig)
                3'b001, 3'b010, 3'b101, 3'b110: mag = {2'b00, a};
                3'b011, 3'b100:                 mag = {1'b0, a, 1'b0};
                default:                        mag = '0;
            endcase
        end

        assign mag_ext = {{(PW-MANT_W-2){1'b0}}, mag};

        // negative digits as two's complement, then weight by 4^i
        always_comb begin
            if (dig[2]) begin
                pp[i] = (~mag_ext + 1'b1) << (2 * i);
            end else begin
                pp[i] = mag_ext << (2 * i);
            end
        end
    end

    // modular sum is exact since the true product fits in PW bits
    always_comb begin
        acc = '0;
        for (int i = 0; i < ND; i++) begin
            acc = acc + pp[i];
        end
    end

    assign p = acc;

endmodule

`default_nettype wire

// ==== logic/fp_mul_unpack.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_mul_unpack (
    input  logic [31:0]             x,
    input  logic [31:0]             y,
    input  logic [2:0]              r_mode,
    output fp_mul_pkg::prod_stage_t prod,
    output logic [23:0]             mant_x,
    output logic [23:0]             mant_y
);

    fp_mul_pkg::fp_class_t cls_x;
    fp_mul_pkg::fp_class_t cls_y;
    logic                  sign;
    logic                  make_nan;
    logic                  make_inf;
    logic                  make_zero;

    function automatic fp_mul_pkg::fp_class_t classify(input logic [31:0] v);
        fp_mul_pkg::fp_class_t c;
        c.is_zero = (v[30:23] == 8'h00);
        c.is_inf  = (v[30:23] == fp_mul_pkg::EXP_ALL_ONES) && (v[22:0] == 23'b0);
        c.is_nan  = (v[30:23] == fp_mul_pkg::EXP_ALL_ONES) && (v[22:0] != 23'b0);
        return c;
    endfunction

    assign cls_x = classify(x);
    assign cls_y = classify(y);
    assign sign  = x[31] ^ y[31];

    // subnormals flushed by dropping the whole significand
    assign mant_x = cls_x.is_zero ? 24'b0 : {1'b1, x[22:0]};
    assign mant_y = cls_y.is_zero ? 24'b0 : {1'b1, y[22:0]};

    // inf x 0 is invalid
    assign make_nan  = cls_x.is_nan || cls_y.is_nan
                    || (cls_x.is_inf && cls_y.is_zero)
                    || (cls_y.is_inf && cls_x.is_zero);
    assign make_inf  = cls_x.is_inf || cls_y.is_inf;
    assign make_zero = cls_x.is_zero || cls_y.is_zero;

    always_comb begin
        prod.sign    = sign;
        prod.exp_sum = $signed({2'b00, x[30:23]}) + $signed({2'b00, y[30:23]})
                     - 10'(fp_mul_pkg::EXP_BIAS);
        // filled in by the booth multiplier at the top level
        prod.product = 48'b0;
        prod.special = make_nan || make_inf || make_zero;
        prod.r_mode  = fp_mul_pkg::rmode_e'(r_mode);

        if (make_nan) begin
            prod.special_z = fp_mul_pkg::QNAN;
        end else if (make_inf) begin
            prod.special_z = {sign, fp_mul_pkg::EXP_ALL_ONES, 23'b0};
        end else begin
            prod.special_z = {sign, 31'b0};
        end
    end

endmodule

`default_nettype wire

// ==== logic/fp_mul_norm.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_mul_norm (
    input  fp_mul_pkg::prod_stage_t prod,
    output fp_mul_pkg::norm_stage_t norm
);

    logic hi;

    // product of two 1.x significands lies in [1, 4)
    assign hi = prod.product[47];

    always_comb begin
        norm.sign      = prod.sign;
        norm.norm_n    = hi;
        norm.special   = prod.special;
        norm.special_z = prod.special_z;
        norm.r_mode    = prod.r_mode;

        if (hi) begin
            norm.mant = {prod.product[47:22], |prod.product[21:0]};
            norm.exp  = prod.exp_sum + 10'sd1;
        end else begin
            norm.mant = {prod.product[46:21], |prod.product[20:0]};
            norm.exp  = prod.exp_sum;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fp_mul_round.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_mul_round (
    input  fp_mul_pkg::norm_stage_t norm,
    output logic [31:0]             z,
    output logic                    ovrf,
    output logic                    udrf
);

    logic              lsb;
    logic              guard;
    logic              sticky;
    logic              tail;
    logic              inc;
    logic              to_inf;
    logic [24:0]       mant_r;
    logic              carry;
    logic [22:0]       frac;
    logic signed [9:0] exp_r;

    assign lsb    = norm.mant[3];
    assign guard  = norm.mant[2];
    // round bit goes into sticky
    assign sticky = |norm.mant[1:0];
    assign tail   = guard | sticky;

    always_comb begin
        case (norm.r_mode)
            fp_mul_pkg::RTZ: inc = 1'b0;
            fp_mul_pkg::RDN: inc = norm.sign & tail;
            fp_mul_pkg::RUP: inc = ~norm.sign & tail;
            fp_mul_pkg::RMM: inc = guard;
            default:         inc = guard & (sticky | lsb);
        endcase
    end

    // saturate to inf only when the mode rounds away from zero
    always_comb begin
        case (norm.r_mode)
            fp_mul_pkg::RTZ: to_inf = 1'b0;
            fp_mul_pkg::RDN: to_inf = norm.sign;
            fp_mul_pkg::RUP: to_inf = ~norm.sign;
            default:         to_inf = 1'b1;
        endcase
    end

    assign mant_r = {1'b0, norm.mant[26:3]} + 25'(inc);
    assign carry  = mant_r[24];
    // a carry leaves the fraction all zero
    assign frac   = mant_r[22:0];
    assign exp_r  = norm.exp + $signed({9'b0, carry});

    always_comb begin
        ovrf = 1'b0;
        udrf = 1'b0;
        if (norm.special) begin
            z = norm.special_z;
        end else if (exp_r >= 10'sd255) begin
            ovrf = 1'b1;
            if (to_inf) begin
                z = {norm.sign, fp_mul_pkg::EXP_ALL_ONES, 23'b0};
            end else begin
                z = {norm.sign, fp_mul_pkg::MAX_FINITE};
            end
        end else if (exp_r < 10'sd1) begin
            // flush to signed zero
            udrf = 1'b1;
            z    = {norm.sign, 31'b0};
        end else begin
            z = {norm.sign, exp_r[7:0], frac};
        end
    end

endmodule

`default_nettype wire

// ==== logic/fp_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_mul #(
    parameter int MANT_W = 24
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    input  logic [31:0] x,
    input  logic [31:0] y,
    input  logic [2:0]  r_mode,
    output logic        out_valid,
    output logic [31:0] z,
    output logic        ovrf,
    output logic        udrf
);

    fp_mul_pkg::prod_stage_t prod_u;
    fp_mul_pkg::prod_stage_t prod_d;
    fp_mul_pkg::prod_stage_t prod_q;
    fp_mul_pkg::norm_stage_t norm_d;
    fp_mul_pkg::norm_stage_t norm_q;

    logic [MANT_W-1:0]   mant_x;
    logic [MANT_W-1:0]   mant_y;
    logic [2*MANT_W-1:0] booth_p;
    logic [31:0]         z_d;
    logic                ovrf_d;
    logic                udrf_d;
    logic                v_s1;
    logic                v_s2;

    // stage 1
    fp_mul_unpack unpack_i (
        .x      (x),
        .y      (y),
        .r_mode (r_mode),
        .prod   (prod_u),
        .mant_x (mant_x),
        .mant_y (mant_y)
    );

    fp_booth_mul #(
        .MANT_W (MANT_W)
    ) booth_i (
        .a (mant_x),
        .b (mant_y),
        .p (booth_p)
    );

    always_comb begin
        prod_d         = prod_u;
        prod_d.product = prod_u.special ? '0 : booth_p;
    end

    // stage 2
    fp_mul_norm norm_i (
        .prod (prod_q),
        .norm (norm_d)
    );

    // stage 3
    fp_mul_round round_i (
        .norm (norm_q),
        .z    (z_d),
        .ovrf (ovrf_d),
        .udrf (udrf_d)
    );

    // payload registers only move with their valid
    always_ff @(posedge clk) begin
        if (in_valid) begin
            prod_q <= prod_d;
        end
        if (v_s1) begin
            norm_q <= norm_d;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            v_s1      <= 1'b0;
            v_s2      <= 1'b0;
            out_valid <= 1'b0;
            z         <= 32'b0;
            ovrf      <= 1'b0;
            udrf      <= 1'b0;
        end else begin
            v_s1      <= in_valid;
            v_s2      <= v_s1;
            out_valid <= v_s2;
            if (v_s2) begin
                z    <= z_d;
                ovrf <= ovrf_d;
                udrf <= udrf_d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 16
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

    // release away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/fp_mul_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_mul_checker (
    input  logic                    clk,
    input  logic                    in_valid,
    input  logic [31:0]             x,
    input  logic [31:0]             y,
    input  logic [47:0]             booth_p,
    input  fp_mul_pkg::prod_stage_t prod_d,
    input  logic                    v_s1,
    input  fp_mul_pkg::prod_stage_t prod_q,
    input  fp_mul_pkg::norm_stage_t norm_d,
    output int                      errors
);

    int                s1_errors = 0;
    int                s2_errors = 0;
    logic [47:0]       exact_p;
    logic [47:0]       aligned;
    logic signed [9:0] exp_exp;

    // hidden bit added, subnormals count as zero
    function automatic logic [23:0] significand(input logic [31:0] v);
        logic [23:0] m;
        if (v[30:23] == 8'h00) begin
            m = 24'h0;
        end else begin
            m = {1'b1, v[22:0]};
        end
        return m;
    endfunction

    assign errors = s1_errors + s2_errors;

    // stage 1 inputs are stable at the rising edge
    always @(posedge clk) begin
        if (in_valid) begin
            exact_p = 48'(significand(x)) * 48'(significand(y));
            if (booth_p !== exact_p) begin
                s1_errors++;
                $display("mismatch at %0t: booth product %h, expected %h",
                         $time, booth_p, exact_p);
            end
            if (prod_d.sign !== (x[31] ^ y[31])) begin
                s1_errors++;
                $display("mismatch at %0t: product sign %b for x %h, y %h",
                         $time, prod_d.sign, x, y);
            end
        end
    end

    // stage 2 checked on the registered product
    always @(negedge clk) begin
        if (v_s1) begin
            aligned = prod_q.product[47] ? prod_q.product : prod_q.product << 1;
            exp_exp = prod_q.exp_sum + (prod_q.product[47] ? 10'sd1 : 10'sd0);
            if (norm_d.mant[26:1] !== aligned[47:22]) begin
                s2_errors++;
                $display("mismatch at %0t: normalized field %h, expected %h",
                         $time, norm_d.mant[26:1], aligned[47:22]);
            end
            if (norm_d.mant[0] !== |aligned[21:0]) begin
                s2_errors++;
                $display("mismatch at %0t: sticky %b for product %h",
                         $time, norm_d.mant[0], prod_q.product);
            end
            if (norm_d.norm_n !== prod_q.product[47]) begin
                s2_errors++;
                $display("mismatch at %0t: norm_n %b for product %h",
                         $time, norm_d.norm_n, prod_q.product);
            end
            if (norm_d.exp !== exp_exp) begin
                s2_errors++;
                $display("mismatch at %0t: normalized exponent %0d, expected %0d",
                         $time, norm_d.exp, exp_exp);
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/fp_mul_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_mul_tb;

    localparam int N_VEC      = 33;
    localparam int N_WORDS    = 5 * N_VEC;
    localparam int N_RAND     = 200;
    localparam int MAX_CYCLES = 16 + 4 * (N_VEC + N_RAND) + 20;

    typedef struct packed {
        logic        check;
        int          idx;
        int          issue;
        logic [31:0] z;
        logic        ovrf;
        logic        udrf;
    } expect_t;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    logic [31:0] x;
    logic [31:0] y;
    logic [2:0]  r_mode;
    logic        out_valid;
    logic [31:0] z;
    logic        ovrf;
    logic        udrf;

    logic [31:0] stim [N_WORDS];
    expect_t     exp_q [$];
    expect_t     got_e;
    logic [31:0] lfsr = 32'h4202_ea0e;
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] rm;
    int          cycles = 0;
    int          errors = 0;
    int          checker_errors;

    tb_clock_gen #(
        .PERIOD_NS    (8.0),
        .RESET_CYCLES (16)
    ) clock_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    fp_mul #(
        .MANT_W (24)
    ) fp_mul_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .x         (x),
        .y         (y),
        .r_mode    (r_mode),
        .out_valid (out_valid),
        .z         (z),
        .ovrf      (ovrf),
        .udrf      (udrf)
    );

    fp_mul_checker checker_i (
        .clk      (clk),
        .in_valid (in_valid),
        .x        (x),
        .y        (y),
        .booth_p  (fp_mul_i.booth_p),
        .prod_d   (fp_mul_i.prod_d),
        .v_s1     (fp_mul_i.v_s1),
        .prod_q   (fp_mul_i.prod_q),
        .norm_d   (fp_mul_i.norm_d),
        .errors   (checker_errors)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic send_op(input logic [31:0] a, input logic [31:0] b,
                           input logic [2:0] m, input logic chk,
                           input logic [31:0] z_exp, input logic [1:0] f_exp,
                           input int idx);
        expect_t e;
        @(negedge clk);
        in_valid = 1'b1;
        x        = a;
        y        = b;
        r_mode   = m;
        e.check  = chk;
        e.idx    = idx;
        e.issue  = cycles;
        e.z      = z_exp;
        e.ovrf   = f_exp[1];
        e.udrf   = f_exp[0];
        exp_q.push_back(e);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // registered outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!arst_n) begin
            if (out_valid || z != 32'b0 || ovrf || udrf) begin
                errors++;
                $display("mismatch at %0t: outputs not cleared during reset", $time);
            end
        end else if (out_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("out_valid raised at %0t with no operation in flight", $time);
            end else begin
                got_e = exp_q.pop_front();
                if (cycles - got_e.issue != 3) begin
                    errors++;
                    $display("mismatch at %0t: op %0d latency %0d cycles, expected 3",
                             $time, got_e.idx, cycles - got_e.issue);
                end
                if (got_e.check && (z !== got_e.z || ovrf !== got_e.ovrf
                                    || udrf !== got_e.udrf)) begin
                    errors++;
                    $display("mismatch at %0t: op %0d z %h ovrf %b udrf %b, expected %h %b %b",
                             $time, got_e.idx, z, ovrf, udrf, got_e.z, got_e.ovrf,
                             got_e.udrf);
                end
            end
        end
    end

    initial begin
        in_valid = 1'b0;
        x        = 32'b0;
        y        = 32'b0;
        r_mode   = 3'b0;
        for (int i = 0; i < N_WORDS; i++) begin
            stim[i] = 32'hffff_ffff;
        end
        $readmemh("sim/fp_mul_stim.txt", stim);
        if (stim[N_WORDS-1] == 32'hffff_ffff) begin
            $display("stim file holds fewer than %0d vectors", N_VEC);
            $display("Simulation failed");
            $finish;
        end else begin
            wait (arst_n == 1'b1);
            idle_cycle();
            // directed vectors with an idle gap after every fourth
            for (int i = 0; i < N_VEC; i++) begin
                send_op(stim[5*i], stim[5*i+1], stim[5*i+2][2:0], 1'b1,
                        stim[5*i+3], stim[5*i+4][1:0], i);
                if (i % 4 == 3) begin
                    idle_cycle();
                end
            end
            // random back-to-back traffic
            for (int i = 0; i < N_RAND; i++) begin
                random_bits(32, ra);
                random_bits(32, rb);
                random_bits(3, rm);
                send_op(ra, rb, rm[2:0], 1'b0, 32'b0, 2'b0, N_VEC + i);
            end
            idle_cycle();
            while (exp_q.size() != 0) begin
                @(negedge clk);
            end
            // nothing may come out while idle
            repeat (8) idle_cycle();
            $display("errors: %0d at the outputs, %0d in the stages", errors,
                     checker_errors);
            if (errors + checker_errors == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim/fp_mul_stim.txt ====
// columns: x  y  mode  expected z  expected flags {ovrf,udrf}
// all fields hex, modes 0 RNE 1 RTZ 2 RDN 3 RUP 4 RMM
40400000 40400000 1 41100000 0
3fc00000 3fc00000 0 40100000 0
3f800001 3fc00000 0 3fc00002 0
3f800003 3fc00000 0 3fc00004 0
3f800003 3fc00000 4 3fc00005 0
3f800001 3fc00000 1 3fc00001 0
bf800001 3fc00000 2 bfc00002 0
bf800001 3fc00000 3 bfc00001 0
3f800001 3fc00000 3 3fc00002 0
3f800001 3fc00000 2 3fc00001 0
3fffffff 3fffffff 0 407ffffe 0
3fffffff 3fffffff 3 407fffff 0
3ffffffe 3f800001 0 40000000 0
3ffffffe 3f800001 1 3fffffff 0
3f800001 3fc00000 5 3fc00002 0
00000000 40400000 0 00000000 0
80000000 40400000 0 80000000 0
00000001 c0400000 0 80000000 0
3f800000 807fffff 3 80000000 0
7f800000 40400000 0 7f800000 0
7f800000 c0000000 1 ff800000 0
ff800000 00000000 0 7fc00000 0
7fc00000 3f800000 0 7fc00000 0
3f800000 ff800001 0 7fc00000 0
7f800000 00000001 0 7fc00000 0
7f000000 40000000 0 7f800000 2
7f000000 40000000 1 7f7fffff 2
ff000000 40000000 2 ff800000 2
ff000000 40000000 3 ff7fffff 2
7f000000 40000000 4 7f800000 2
00800000 3f000000 0 00000000 1
80800000 3f000000 0 80000000 1
0d800000 0d800000 0 00000000 1

// ==== sources.f ====
logic/fp_mul_pkg.sv
logic/fp_booth_mul.sv
logic/fp_mul_unpack.sv
logic/fp_mul_norm.sv
logic/fp_mul_round.sv
logic/fp_mul.sv
sim/tb_clock_gen.sv
sim/fp_mul_checker.sv
sim/fp_mul_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f sources.f --top-module fp_mul_tb \
    -Mdir obj_dir -o fp_mul_sim

./obj_dir/fp_mul_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
